// ==== rtl/core_cfg_pkg.sv ====
// Stack machine configuration

package core_cfg_pkg;

	// data path
	localparam int WORD_W = 56;       // width of one stack word
	localparam int TRACE_W = 8;       // width of the trace output

	// data stack geometry
	localparam int STACK_DEPTH = 8;   // max items held
	localparam int DEPTH_W = 4;       // holds 0..STACK_DEPTH

	// error codes reported on the host port
	// a code stays until the next fault or reset
	typedef enum logic [3:0] {
		ERR_NONE    = 4'd0, // no fault seen
		ERR_DSFULL  = 4'd1, // push onto a full stack
		ERR_DSEMPTY = 4'd2, // pop or peek past the bottom
		ERR_INVALID = 4'd3  // opcode not decoded
	} err_e;

endpackage

// ==== rtl/cpu_isa_pkg.sv ====
// Stack machine instruction set

package cpu_isa_pkg;

	localparam int OPC_W = 7;     // one opcode
	localparam int INSTR_W = 14;  // two opcodes, low one runs first

	// opcode map, grouped by operand count
	typedef enum logic [OPC_W-1:0] {
		// stack handling
		NOP   = 7'h00,
		DEPTH = 7'h01, // push item count
		DUP   = 7'h02,
		EMPTY = 7'h03, // drop everything
		TRACE = 7'h04, // low byte of top to trace output
		DROP  = 7'h05,

		// unary, work on the top word in place
		COM   = 7'h10, // two's complement
		NOT   = 7'h11,
		INC   = 7'h12,
		DEC   = 7'h13,

		// binary, second op top
		GT    = 7'h20,
		GTEQ  = 7'h21,
		SM    = 7'h22,
		SMEQ  = 7'h23,
		EQ    = 7'h24,
		NEQ   = 7'h25,
		AND   = 7'h26,
		OR    = 7'h27,
		XOR   = 7'h28,
		SHL   = 7'h29,
		SHR   = 7'h2A,
		ADD   = 7'h2B,
		SUB   = 7'h2C
	} opcode_e;

endpackage

// ==== rtl/data_stack.sv ====
// Data stack LIFO

module data_stack (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             i_push,
	input  logic                             i_pop,
	input  logic                             i_peek,
	input  logic                             i_poke,
	input  logic                             i_clear,
	input  logic [core_cfg_pkg::DEPTH_W-1:0] i_index,
	input  logic [core_cfg_pkg::WORD_W-1:0]  i_data,
	output logic [core_cfg_pkg::WORD_W-1:0]  o_data,
	output logic [core_cfg_pkg::DEPTH_W-1:0] o_depth,
	output logic                             o_full,
	output logic                             o_empty
);

	// items sit from the bottom up, the top is at depth-1
	logic [core_cfg_pkg::WORD_W-1:0]  mem [core_cfg_pkg::STACK_DEPTH];
	logic [core_cfg_pkg::DEPTH_W-2:0] top_slot;  // slot of index 0
	logic [core_cfg_pkg::DEPTH_W-2:0] acc_slot;  // slot of i_index
	logic [core_cfg_pkg::DEPTH_W-2:0] push_slot; // first free slot

	assign push_slot = o_depth[core_cfg_pkg::DEPTH_W-2:0];
	assign top_slot  = push_slot - 1'b1;
	assign acc_slot  = top_slot - i_index[core_cfg_pkg::DEPTH_W-2:0]; // counts down from top

	assign o_full  = (o_depth == core_cfg_pkg::STACK_DEPTH);
	assign o_empty = (o_depth == '0);

	// item count
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			o_depth <= '0;
		end else if (i_clear) begin
			o_depth <= '0;
		end else if (i_push) begin
			o_depth <= o_depth + 1'b1;
		end else if (i_pop) begin
			o_depth <= o_depth - 1'b1;
		end
	end

	// storage and read port
	always_ff @(posedge clk) begin
		if (i_push) begin
			mem[push_slot] <= i_data;
		end else if (i_poke) begin
			mem[acc_slot] <= i_data; // replace in place
		end

		if (i_pop) begin
			o_data <= mem[top_slot]; // old top
		end else if (i_peek) begin
			o_data <= mem[acc_slot];
		end
	end

endmodule

// ==== rtl/stack_alu.sv ====
// Stack word ALU

module stack_alu (
	input  cpu_isa_pkg::opcode_e            i_opcode,
	input  logic [core_cfg_pkg::WORD_W-1:0] i_top,    // last pushed
	input  logic [core_cfg_pkg::WORD_W-1:0] i_second,
	output logic [core_cfg_pkg::WORD_W-1:0] o_result,
	output logic                            o_valid
);

	always_comb begin
		o_result = '0;
		o_valid  = 1'b1;
		case (i_opcode)
			// unary on top
			cpu_isa_pkg::COM:  o_result = ~i_top + 1'b1;
			cpu_isa_pkg::NOT:  o_result = ~i_top;
			cpu_isa_pkg::INC:  o_result = i_top + 1'b1;
			cpu_isa_pkg::DEC:  o_result = i_top - 1'b1;

			// unsigned compares give 0 or 1 in a full word
			cpu_isa_pkg::GT:   o_result[0] = (i_second >  i_top);
			cpu_isa_pkg::GTEQ: o_result[0] = (i_second >= i_top);
			cpu_isa_pkg::SM:   o_result[0] = (i_second <  i_top);
			cpu_isa_pkg::SMEQ: o_result[0] = (i_second <= i_top);
			cpu_isa_pkg::EQ:   o_result[0] = (i_second == i_top);
			cpu_isa_pkg::NEQ:  o_result[0] = (i_second != i_top);

			cpu_isa_pkg::AND:  o_result = i_second & i_top;
			cpu_isa_pkg::OR:   o_result = i_second | i_top;
			cpu_isa_pkg::XOR:  o_result = i_second ^ i_top;
			cpu_isa_pkg::SHL:  o_result = i_second << i_top; // top is the distance
			cpu_isa_pkg::SHR:  o_result = i_second >> i_top;
			cpu_isa_pkg::ADD:  o_result = i_second + i_top;  // wraps
			cpu_isa_pkg::SUB:  o_result = i_second - i_top;
			default:           o_valid  = 1'b0; // stack ops and unknown codes
		endcase
	end

endmodule

// ==== rtl/core_seq.sv ====
// Instruction sequencer

module core_seq (
	input  logic                             clk,
	input  logic                             rst_n,
	// host port
	input  logic                             i_push_en,
	input  logic                             i_instr_en,
	input  logic [core_cfg_pkg::WORD_W-1:0]  i_push_value,
	input  logic [cpu_isa_pkg::INSTR_W-1:0]  i_instr,
	output logic                             o_idle,
	// data stack
	output logic                             o_stk_push,
	output logic                             o_stk_pop,
	output logic                             o_stk_peek,
	output logic                             o_stk_poke,
	output logic                             o_stk_clear,
	output logic [core_cfg_pkg::DEPTH_W-1:0] o_stk_index,
	output logic [core_cfg_pkg::WORD_W-1:0]  o_stk_data,
	input  logic [core_cfg_pkg::WORD_W-1:0]  i_stk_data,
	input  logic [core_cfg_pkg::DEPTH_W-1:0] i_stk_depth,
	input  logic                             i_stk_full,
	input  logic                             i_stk_empty,
	// ALU
	output cpu_isa_pkg::opcode_e             o_alu_opcode,
	output logic [core_cfg_pkg::WORD_W-1:0]  o_alu_top,
	output logic [core_cfg_pkg::WORD_W-1:0]  o_alu_second,
	input  logic [core_cfg_pkg::WORD_W-1:0]  i_alu_result,
	input  logic                             i_alu_valid,
	// status block
	output logic                             o_err_strobe,
	output core_cfg_pkg::err_e               o_err_code,
	output logic                             o_trace_strobe,
	output logic [core_cfg_pkg::TRACE_W-1:0] o_trace_value
);

	typedef enum logic [3:0] {
		S_IDLE,
		S_EXEC,   // decode current opcode
		S_PUSH,   // checked stack accesses, then ret_state
		S_POP,
		S_PEEK,
		S_POKE,
		S_DUP,
		S_TRACE,
		S_UNARY,
		S_BIN_A,  // top popped
		S_BIN_B,  // second popped
		S_NEXT    // opcode done
	} seq_state_e;

	seq_state_e                       state;
	seq_state_e                       ret_state;
	logic                             hi_q;     // running the high opcode
	logic [cpu_isa_pkg::INSTR_W-1:0]  instr_q;
	cpu_isa_pkg::opcode_e             opcode_q;
	logic [core_cfg_pkg::DEPTH_W-1:0] index_q;
	logic [core_cfg_pkg::WORD_W-1:0]  data_q;   // word for push or poke
	logic [core_cfg_pkg::WORD_W-1:0]  top_q;    // first operand of a binary op

	assign o_idle       = (state == S_IDLE);
	assign o_stk_index  = index_q;
	assign o_stk_data   = data_q;
	assign o_alu_opcode = opcode_q;
	assign o_alu_top    = (state == S_UNARY) ? i_stk_data : top_q;
	assign o_alu_second = i_stk_data;
	assign o_trace_value = i_stk_empty ? '1 : i_stk_data[core_cfg_pkg::TRACE_W-1:0];

	// strobes and fault checks for the current state
	always_comb begin
		o_stk_push     = 1'b0;
		o_stk_pop      = 1'b0;
		o_stk_peek     = 1'b0;
		o_stk_poke     = 1'b0;
		o_stk_clear    = 1'b0;
		o_trace_strobe = 1'b0;
		o_err_strobe   = 1'b0;
		o_err_code     = core_cfg_pkg::ERR_NONE;
		case (state)
			S_PUSH: begin
				o_err_strobe = i_stk_full;
				o_err_code   = core_cfg_pkg::ERR_DSFULL;
				o_stk_push   = !i_stk_full;
			end
			S_POP: begin
				o_err_strobe = i_stk_empty;
				o_err_code   = core_cfg_pkg::ERR_DSEMPTY;
				o_stk_pop    = !i_stk_empty;
			end
			S_PEEK, S_POKE: begin
				// index must point at an existing item
				o_err_strobe = (index_q >= i_stk_depth);
				o_err_code   = core_cfg_pkg::ERR_DSEMPTY;
				o_stk_peek   = (state == S_PEEK) && !o_err_strobe;
				o_stk_poke   = (state == S_POKE) && !o_err_strobe;
			end
			S_EXEC: begin
				case (opcode_q)
					cpu_isa_pkg::EMPTY: o_stk_clear = 1'b1;
					cpu_isa_pkg::NOP, cpu_isa_pkg::DEPTH, cpu_isa_pkg::DUP,
					cpu_isa_pkg::TRACE, cpu_isa_pkg::DROP: ;
					default: begin
						o_err_strobe = !i_alu_valid; // not an ALU op either
						o_err_code   = core_cfg_pkg::ERR_INVALID;
					end
				endcase
			end
			S_TRACE: o_trace_strobe = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= S_IDLE;
			ret_state <= S_IDLE;
			hi_q      <= 1'b0;
		end else if (o_err_strobe) begin
			state <= S_IDLE; // fault ends the request, high opcode skipped
		end else begin
			case (state)
				S_IDLE: begin
					if (i_push_en) begin
						data_q    <= i_push_value;
						ret_state <= S_IDLE;
						state     <= S_PUSH;
					end else if (i_instr_en) begin
						instr_q  <= i_instr;
						opcode_q <= cpu_isa_pkg::opcode_e'(i_instr[cpu_isa_pkg::OPC_W-1:0]);
						hi_q     <= 1'b0;
						state    <= S_EXEC;
					end
				end
				S_EXEC: begin
					index_q <= '0; // every access here is at the top
					case (opcode_q)
						cpu_isa_pkg::NOP, cpu_isa_pkg::EMPTY: state <= S_NEXT;
						cpu_isa_pkg::DEPTH: begin
							data_q <= {{(core_cfg_pkg::WORD_W - core_cfg_pkg::DEPTH_W){1'b0}},
								i_stk_depth};
							ret_state <= S_NEXT;
							state     <= S_PUSH;
						end
						cpu_isa_pkg::DUP: begin
							ret_state <= S_DUP;
							state     <= S_PEEK;
						end
						cpu_isa_pkg::TRACE: begin
							ret_state <= S_TRACE;
							state     <= i_stk_empty ? S_TRACE : S_PEEK; // empty gives all ones
						end
						cpu_isa_pkg::DROP: begin
							ret_state <= S_NEXT;
							state     <= S_POP;
						end
						cpu_isa_pkg::COM, cpu_isa_pkg::NOT, cpu_isa_pkg::INC,
						cpu_isa_pkg::DEC: begin
							ret_state <= S_UNARY;
							state     <= S_PEEK;
						end
						default: begin
							ret_state <= S_BIN_A;
							state     <= S_POP;
						end
					endcase
				end
				S_PUSH, S_POP, S_PEEK, S_POKE: state <= ret_state;
				S_DUP: begin
					data_q    <= i_stk_data;
					ret_state <= S_NEXT;
					state     <= S_PUSH;
				end
				S_TRACE: state <= S_NEXT;
				S_UNARY: begin
					data_q    <= i_alu_result;
					ret_state <= S_NEXT;
					state     <= S_POKE; // overwrite top in place
				end
				S_BIN_A: begin
					top_q     <= i_stk_data;
					ret_state <= S_BIN_B;
					state     <= S_POP;
				end
				S_BIN_B: begin
					data_q    <= i_alu_result;
					ret_state <= S_NEXT;
					state     <= S_PUSH;
				end
				S_NEXT: begin
					if (hi_q) begin
						state <= S_IDLE;
					end else begin
						hi_q     <= 1'b1;
						opcode_q <= cpu_isa_pkg::opcode_e'(
							instr_q[cpu_isa_pkg::INSTR_W-1:cpu_isa_pkg::OPC_W]);
						state    <= S_EXEC;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

endmodule

// ==== rtl/status_regs.sv ====
// Error and trace status

module status_regs (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             i_err_strobe,
	input  core_cfg_pkg::err_e               i_err_code,
	input  logic                             i_trace_strobe,
	input  logic [core_cfg_pkg::TRACE_W-1:0] i_trace_value,
	output core_cfg_pkg::err_e               o_errcode,
	output logic [core_cfg_pkg::TRACE_W-1:0] o_trace
);

	// last fault, sticky until reset or the next fault
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			o_errcode <= core_cfg_pkg::ERR_NONE;
		end else if (i_err_strobe) begin
			o_errcode <= i_err_code;
		end
	end

	// trace output, all ones until first TRACE
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			o_trace <= '1;
		end else if (i_trace_strobe) begin
			o_trace <= i_trace_value;
		end
	end

endmodule

// ==== rtl/core_top.sv ====
// Stack machine core

module core_top (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             i_push_en,
	input  logic [core_cfg_pkg::WORD_W-1:0]  i_push_value,
	input  logic                             i_instr_en,
	input  logic [cpu_isa_pkg::INSTR_W-1:0]  i_instr,
	output logic                             o_idle,
	output core_cfg_pkg::err_e               o_errcode,
	output logic [core_cfg_pkg::TRACE_W-1:0] o_trace
);

	// sequencer to stack
	logic                             stk_push, stk_pop, stk_peek, stk_poke, stk_clear;
	logic [core_cfg_pkg::DEPTH_W-1:0] stk_index, stk_depth;
	logic [core_cfg_pkg::WORD_W-1:0]  stk_wdata, stk_rdata;
	logic                             stk_full, stk_empty;
	// sequencer to ALU
	cpu_isa_pkg::opcode_e             alu_opcode;
	logic [core_cfg_pkg::WORD_W-1:0]  alu_top, alu_second, alu_result;
	logic                             alu_valid;
	// sequencer to status
	logic                             err_strobe, trace_strobe;
	core_cfg_pkg::err_e               err_code;
	logic [core_cfg_pkg::TRACE_W-1:0] trace_value;

	core_seq seq0 (
		.clk, .rst_n,
		.i_push_en, .i_instr_en, .i_push_value, .i_instr, .o_idle,
		.o_stk_push(stk_push), .o_stk_pop(stk_pop), .o_stk_peek(stk_peek),
		.o_stk_poke(stk_poke), .o_stk_clear(stk_clear),
		.o_stk_index(stk_index), .o_stk_data(stk_wdata),
		.i_stk_data(stk_rdata), .i_stk_depth(stk_depth),
		.i_stk_full(stk_full), .i_stk_empty(stk_empty),
		.o_alu_opcode(alu_opcode), .o_alu_top(alu_top), .o_alu_second(alu_second),
		.i_alu_result(alu_result), .i_alu_valid(alu_valid),
		.o_err_strobe(err_strobe), .o_err_code(err_code),
		.o_trace_strobe(trace_strobe), .o_trace_value(trace_value)
	);

	data_stack stack0 (
		.clk, .rst_n,
		.i_push(stk_push), .i_pop(stk_pop), .i_peek(stk_peek), .i_poke(stk_poke),
		.i_clear(stk_clear), .i_index(stk_index), .i_data(stk_wdata),
		.o_data(stk_rdata), .o_depth(stk_depth), .o_full(stk_full), .o_empty(stk_empty)
	);

	stack_alu alu0 (
		.i_opcode(alu_opcode), .i_top(alu_top), .i_second(alu_second),
		.o_result(alu_result), .o_valid(alu_valid)
	);

	status_regs status0 (
		.clk, .rst_n,
		.i_err_strobe(err_strobe), .i_err_code(err_code),
		.i_trace_strobe(trace_strobe), .i_trace_value(trace_value),
		.o_errcode, .o_trace
	);

endmodule

// ==== tests/core_checker.sv ====
// Stack core reference checker

module core_checker (
	input  logic                             clk,
	input  logic                             rst_n,
	input  logic                             i_push_en,
	input  logic [core_cfg_pkg::WORD_W-1:0]  i_push_value,
	input  logic                             i_instr_en,
	input  logic [cpu_isa_pkg::INSTR_W-1:0]  i_instr,
	input  logic                             i_idle,
	input  core_cfg_pkg::err_e               i_errcode,
	input  logic [core_cfg_pkg::TRACE_W-1:0] i_trace,
	output int                               o_checks,
	output int                               o_err_errors,
	output int                               o_trace_errors
);
	timeunit 1ns;
	timeprecision 100ps;

	string                            test_name = "reset"; // written by tb_top
	string                            req_name;            // request in flight
	logic [core_cfg_pkg::WORD_W-1:0]  stk[$];              // back is the top
	core_cfg_pkg::err_e               exp_err;
	logic [core_cfg_pkg::TRACE_W-1:0] exp_trace;
	logic                             idle_q;
	int                               checks = 0;
	int                               err_errors = 0;
	int                               trace_errors = 0;

	assign o_checks       = checks;
	assign o_err_errors   = err_errors;
	assign o_trace_errors = trace_errors;

	// second op top, unsigned, modulo 2^56
	function automatic logic [core_cfg_pkg::WORD_W-1:0] alu_ref(
		input logic [cpu_isa_pkg::OPC_W-1:0]  opc,
		input logic [core_cfg_pkg::WORD_W-1:0] second,
		input logic [core_cfg_pkg::WORD_W-1:0] top
	);
		case (opc)
			cpu_isa_pkg::COM:  return -top;
			cpu_isa_pkg::NOT:  return ~top;
			cpu_isa_pkg::INC:  return top + 1;
			cpu_isa_pkg::DEC:  return top - 1;
			cpu_isa_pkg::GT:   return second > top;
			cpu_isa_pkg::GTEQ: return second >= top;
			cpu_isa_pkg::SM:   return second < top;
			cpu_isa_pkg::SMEQ: return second <= top;
			cpu_isa_pkg::EQ:   return second == top;
			cpu_isa_pkg::NEQ:  return second != top;
			cpu_isa_pkg::AND:  return second & top;
			cpu_isa_pkg::OR:   return second | top;
			cpu_isa_pkg::XOR:  return second ^ top;
			cpu_isa_pkg::SHL:  return (top >= core_cfg_pkg::WORD_W) ? '0 : second << top;
			cpu_isa_pkg::SHR:  return (top >= core_cfg_pkg::WORD_W) ? '0 : second >> top;
			cpu_isa_pkg::ADD:  return second + top;
			cpu_isa_pkg::SUB:  return second - top;
			default:           return '0;
		endcase
	endfunction

	function automatic bit raise_fault(input core_cfg_pkg::err_e code);
		exp_err = code;
		return 1'b0;
	endfunction

	// one opcode on the model, 0 when it faults
	function automatic bit run_opcode(input logic [cpu_isa_pkg::OPC_W-1:0] opc);
		logic [core_cfg_pkg::WORD_W-1:0] top;
		logic [core_cfg_pkg::WORD_W-1:0] second;
		case (opc)
			cpu_isa_pkg::NOP: ;
			cpu_isa_pkg::DEPTH: begin
				if (stk.size() == core_cfg_pkg::STACK_DEPTH) return raise_fault(core_cfg_pkg::ERR_DSFULL);
				top = stk.size(); // count before the push
				stk.push_back(top);
			end
			cpu_isa_pkg::DUP: begin
				if (stk.size() == 0) return raise_fault(core_cfg_pkg::ERR_DSEMPTY);
				if (stk.size() == core_cfg_pkg::STACK_DEPTH) return raise_fault(core_cfg_pkg::ERR_DSFULL);
				top = stk[$];
				stk.push_back(top);
			end
			cpu_isa_pkg::EMPTY: stk.delete();
			cpu_isa_pkg::TRACE: begin
				if (stk.size() == 0) begin
					exp_trace = '1;
				end else begin
					top = stk[$];
					exp_trace = top[core_cfg_pkg::TRACE_W-1:0];
				end
			end
			cpu_isa_pkg::DROP: begin
				if (stk.size() == 0) return raise_fault(core_cfg_pkg::ERR_DSEMPTY);
				void'(stk.pop_back());
			end
			default: begin
				if (opc inside {[cpu_isa_pkg::COM:cpu_isa_pkg::DEC]}) begin
					if (stk.size() == 0) return raise_fault(core_cfg_pkg::ERR_DSEMPTY);
					top = stk.pop_back();
					stk.push_back(alu_ref(opc, '0, top));
				end else if (opc inside {[cpu_isa_pkg::GT:cpu_isa_pkg::SUB]}) begin
					if (stk.size() == 0) return raise_fault(core_cfg_pkg::ERR_DSEMPTY);
					top = stk.pop_back(); // gone even if second is missing
					if (stk.size() == 0) return raise_fault(core_cfg_pkg::ERR_DSEMPTY);
					second = stk.pop_back();
					stk.push_back(alu_ref(opc, second, top));
				end else begin
					return raise_fault(core_cfg_pkg::ERR_INVALID);
				end
			end
		endcase
		return 1'b1;
	endfunction

	// low opcode first, a fault skips the high one
	function automatic void apply_request(
		input logic                            is_push,
		input logic [core_cfg_pkg::WORD_W-1:0] value,
		input logic [cpu_isa_pkg::INSTR_W-1:0] word
	);
		if (is_push) begin
			if (stk.size() == core_cfg_pkg::STACK_DEPTH) exp_err = core_cfg_pkg::ERR_DSFULL;
			else stk.push_back(value);
		end else if (run_opcode(word[cpu_isa_pkg::OPC_W-1:0])) begin
			void'(run_opcode(word[cpu_isa_pkg::INSTR_W-1:cpu_isa_pkg::OPC_W]));
		end
	endfunction

	function automatic void compare_outputs();
		checks++;
		if (i_errcode !== exp_err) begin
			err_errors++;
			$display("FAIL %s: errcode expected %0d actual %0d", req_name, exp_err, i_errcode);
		end
		if (i_trace !== exp_trace) begin
			trace_errors++;
			$display("FAIL %s: trace expected 0x%02h actual 0x%02h", req_name, exp_trace, i_trace);
		end
	endfunction

	// negedge sampling, inputs and outputs settled
	always @(negedge clk) begin
		if (!rst_n) begin
			stk.delete();
			exp_err   = core_cfg_pkg::ERR_NONE;
			exp_trace = '1;
			idle_q    = 1'b0; // first idle after reset checks the reset values
			req_name  = "reset";
		end else begin
			if (i_idle && !idle_q) compare_outputs();
			if (i_idle && (i_push_en || i_instr_en)) begin
				req_name = test_name;
				apply_request(i_push_en, i_push_value, i_instr); // push wins
			end
			idle_q = i_idle;
		end
	end

endmodule

// ==== tests/tb_top.sv ====
// Stack core testbench

module tb_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N_UNARY_VALS = 3;  // zero, all ones, random
	localparam int N_BIN_OPS    = 13;
	localparam int N_PAIRS      = 3;  // one equal pair, two random
	// stack tests, loops, then faults and misc
	localparam int N_REQ = 10 + 4 * N_UNARY_VALS * 3 + N_BIN_OPS * N_PAIRS * 4 + 40;
	localparam int WATCHDOG_CYCLES = N_REQ * 20 + 100;

	logic                             clk;
	logic                             rst_n;
	logic                             push_en;
	logic [core_cfg_pkg::WORD_W-1:0]  push_value;
	logic                             instr_en;
	logic [cpu_isa_pkg::INSTR_W-1:0]  instr;
	logic                             idle;
	core_cfg_pkg::err_e               errcode;
	logic [core_cfg_pkg::TRACE_W-1:0] trace;
	int                               checks;
	int                               err_errors;
	int                               trace_errors;
	bit                               timed_out = 1'b0;
	logic [31:0]                      seed = 32'h7754;

	core_top dut0 (
		.clk, .rst_n,
		.i_push_en(push_en), .i_push_value(push_value),
		.i_instr_en(instr_en), .i_instr(instr),
		.o_idle(idle), .o_errcode(errcode), .o_trace(trace)
	);

	core_checker chk0 (
		.clk, .rst_n,
		.i_push_en(push_en), .i_push_value(push_value),
		.i_instr_en(instr_en), .i_instr(instr),
		.i_idle(idle), .i_errcode(errcode), .i_trace(trace),
		.o_checks(checks), .o_err_errors(err_errors), .o_trace_errors(trace_errors)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic [core_cfg_pkg::WORD_W-1:0] rand_word();
		logic [31:0] hi;
		logic [31:0] lo;
		hi = lcg_next();
		lo = lcg_next();
		return {hi[23:0], lo};
	endfunction

	// one host request entered 1 ns after a rising edge
	task automatic send(
		input logic                            is_push,
		input logic [core_cfg_pkg::WORD_W-1:0] value,
		input logic [cpu_isa_pkg::INSTR_W-1:0] word,
		input bit                              noise
	);
		while (!idle) begin
			@(posedge clk);
			#1;
		end
		push_en    = is_push;
		push_value = value;
		instr_en   = !is_push;
		instr      = word;
		@(posedge clk); // accepted here
		#1;
		push_en  = 1'b0;
		instr_en = 1'b0;
		if (noise) begin
			// both requests while busy are dropped
			push_en    = 1'b1;
			push_value = rand_word();
			instr_en   = 1'b1;
			instr      = {cpu_isa_pkg::NOP, cpu_isa_pkg::EMPTY};
			@(posedge clk);
			#1;
			push_en  = 1'b0;
			instr_en = 1'b0;
		end
		while (!idle) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic push_word(input logic [core_cfg_pkg::WORD_W-1:0] v);
		send(1'b1, v, '0, 1'b0);
	endtask

	task automatic issue(
		input logic [cpu_isa_pkg::OPC_W-1:0] lo,
		input logic [cpu_isa_pkg::OPC_W-1:0] hi
	);
		send(1'b0, '0, {hi, lo}, 1'b0);
	endtask

	// fills an empty stack, low bytes base+1 up to base+8
	task automatic fill_stack(input logic [7:0] base);
		logic [core_cfg_pkg::WORD_W-1:0] v;
		for (int i = 1; i <= core_cfg_pkg::STACK_DEPTH; i++) begin
			v = rand_word();
			v[7:0] = base + 8'(i); // low byte never all ones
			push_word(v);
		end
	endtask

	task automatic start_test(input string name);
		chk0.test_name = name;
	endtask

	task automatic end_run();
		$display("checks %0d, errcode errors %0d, trace errors %0d, timeouts %0d",
			checks, err_errors, trace_errors, timed_out);
		if (checks > 0 && err_errors == 0 && trace_errors == 0 && !timed_out) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: DUT did not finish its requests within %0d cycles", WATCHDOG_CYCLES);
		timed_out = 1'b1;
		end_run();
	end

	initial begin
		logic [core_cfg_pkg::WORD_W-1:0]  a;
		logic [core_cfg_pkg::WORD_W-1:0]  b;
		logic [cpu_isa_pkg::OPC_W-1:0]    op;
		rst_n      = 1'b0;
		push_en    = 1'b0;
		push_value = '0;
		instr_en   = 1'b0;
		instr      = '0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;

		start_test("stack_ops");
		for (int i = 0; i < 3; i++) push_word(rand_word());
		issue(cpu_isa_pkg::TRACE, cpu_isa_pkg::NOP);
		issue(cpu_isa_pkg::DEPTH, cpu_isa_pkg::TRACE); // count before the push
		issue(cpu_isa_pkg::DUP, cpu_isa_pkg::TRACE);
		issue(cpu_isa_pkg::DROP, cpu_isa_pkg::TRACE);
		issue(cpu_isa_pkg::DROP, cpu_isa_pkg::DROP);
		issue(cpu_isa_pkg::TRACE, cpu_isa_pkg::NOP);   // second value pushed
		issue(cpu_isa_pkg::EMPTY, cpu_isa_pkg::NOP);

		for (int u = 0; u < 4; u++) begin
			op = cpu_isa_pkg::COM + u;
			for (int k = 0; k < N_UNARY_VALS; k++) begin
				a = (k == 0) ? '0 : (k == 1) ? '1 : rand_word(); // wrap cases first
				start_test($sformatf("unary_%02h_%0d", op, k));
				push_word(a);
				issue(op, cpu_isa_pkg::TRACE);
				issue(cpu_isa_pkg::DROP, cpu_isa_pkg::NOP);
			end
		end

		for (int o = 0; o < N_BIN_OPS; o++) begin
			op = cpu_isa_pkg::GT + o;
			for (int k = 0; k < N_PAIRS; k++) begin
				a = rand_word();
				b = (k == 0) ? a : rand_word();
				if (op == cpu_isa_pkg::SHL || op == cpu_isa_pkg::SHR) b = b % 64; // some past 55
				start_test($sformatf("binary_%02h_%0d", op, k));
				push_word(a);
				push_word(b);
				issue(op, cpu_isa_pkg::TRACE);
				issue(cpu_isa_pkg::DROP, cpu_isa_pkg::NOP);
			end
		end

		start_test("push_full");
		issue(cpu_isa_pkg::EMPTY, cpu_isa_pkg::NOP);
		fill_stack(8'h00);
		push_word(rand_word()); // ninth
		issue(cpu_isa_pkg::TRACE, cpu_isa_pkg::NOP);
		start_test("drop_empty");
		issue(cpu_isa_pkg::EMPTY, cpu_isa_pkg::NOP);
		issue(cpu_isa_pkg::DROP, cpu_isa_pkg::TRACE); // trace must stay
		start_test("dup_full");
		fill_stack(8'h10);
		issue(cpu_isa_pkg::DUP, cpu_isa_pkg::TRACE); // trace must stay
		start_test("binary_one_item");
		issue(cpu_isa_pkg::EMPTY, cpu_isa_pkg::NOP);
		push_word(rand_word());
		issue(cpu_isa_pkg::ADD, cpu_isa_pkg::TRACE);
		issue(cpu_isa_pkg::TRACE, cpu_isa_pkg::NOP);

		start_test("invalid");
		a = rand_word();
		a[7:0] = 8'h5A;
		push_word(a);
		issue(7'h06, cpu_isa_pkg::TRACE);
		issue(cpu_isa_pkg::TRACE, cpu_isa_pkg::NOP);
		start_test("empty");
		push_word(rand_word());
		issue(cpu_isa_pkg::EMPTY, cpu_isa_pkg::TRACE);
		start_test("busy");
		push_word(rand_word());
		push_word(rand_word());
		send(1'b0, '0, {cpu_isa_pkg::TRACE, cpu_isa_pkg::ADD}, 1'b1);
		issue(cpu_isa_pkg::DROP, cpu_isa_pkg::TRACE); // empty unless a busy push got in
		start_test("invalid_7f");
		issue(cpu_isa_pkg::DROP, cpu_isa_pkg::NOP); // errcode moves off ERR_INVALID first
		issue(7'h7F, cpu_isa_pkg::NOP);

		repeat (2) @(posedge clk); // last compare happens on the negedge
		end_run();
	end

endmodule

// ==== vlog.f ====
rtl/core_cfg_pkg.sv
rtl/cpu_isa_pkg.sv
rtl/data_stack.sv
rtl/stack_alu.sv
rtl/core_seq.sv
rtl/status_regs.sv
rtl/core_top.sv
tests/core_checker.sv
tests/tb_top.sv

// ==== Bender.yml ====
package:
  name: stack_core

sources:
  - rtl/core_cfg_pkg.sv
  - rtl/cpu_isa_pkg.sv
  - rtl/data_stack.sv
  - rtl/stack_alu.sv
  - rtl/core_seq.sv
  - rtl/status_regs.sv
  - rtl/core_top.sv
  - target: simulation
    files:
      - tests/core_checker.sv
      - tests/tb_top.sv
